// ==== irem62_params.svh ====
// Shared constants of the M62 board shell
// ROM map, download indices, reset hold and hardware variant codes
`ifndef IREM62_PARAMS_SVH
`define IREM62_PARAMS_SVH

// Download bus widths
`define IREM_ADDR_W      25
`define IREM_OFFSET_W    18

// Download stream indices
`define IREM_IDX_ROM     8'd0
`define IREM_IDX_VARIANT 8'd1
`define IREM_IDX_DIP     8'd254

// ROM image layout, region start addresses
`define IREM_BASE_CPU    25'h0000000
`define IREM_BASE_SND    25'h0020000
`define IREM_BASE_GFX1   25'h0030000
`define IREM_BASE_GFX2   25'h0050000
`define IREM_BASE_GFX3   25'h0090000
`define IREM_BASE_PROM   25'h00A0000
`define IREM_ROM_END     25'h00A0920

// Game reset hold after the last request
`define IREM_RESET_HOLD  16'd65535

// Hardware variants with a portrait screen
`define IREM_VAR_BATTROAD 8'h06
`define IREM_VAR_YOUJYUDN 8'h0B

`endif

// ==== irem62_pkg.sv ====
// Types of the M62 board shell
// Download and ROM write beats, config strobes, menu status, controls
`include "irem62_params.svh"

package irem62_pkg;

	// ROM regions of the download image
	typedef enum logic [2:0] {
		rom_cpu  = 3'd0,
		rom_snd  = 3'd1,
		rom_gfx1 = 3'd2,
		rom_gfx2 = 3'd3,
		rom_gfx3 = 3'd4,
		rom_prom = 3'd5
	} rom_region_e;

	typedef struct packed {
		logic [7:0]              index;
		logic [`IREM_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} dl_beat_t;

	typedef struct packed {
		rom_region_e               region;
		logic [`IREM_OFFSET_W-1:0] offset;
		logic [7:0]                data;
	} rom_wr_t;

	typedef struct packed {
		logic       var_wr;
		logic       dip_wr;
		logic       dip_slot;
		logic [7:0] data;
	} cfg_wr_t;

	// joy_mode: 0 off, 1 DB9 Mega Drive, 2 DB15
	typedef struct packed {
		logic       reset_req;
		logic       horizontal;
		logic [1:0] aspect;
		logic [1:0] joy_mode;
		logic       two_players;
	} menu_status_t;

	// ==============================
	// User-port joystick word
	// ==============================
	typedef struct packed {
		logic [3:0] unused;
		logic mode, start, z, y, x, a, c, b;
		logic up, down, left, right;
	} joy_db9md_t;

	typedef struct packed {
		logic [3:0] unused;
		logic l, start, f, e, d, c, b, a;
		logic up, down, left, right;
	} joy_db15_t;

	typedef union packed {
		joy_db9md_t db9md;
		joy_db15_t  db15;
	} joy_word_u;

	typedef struct packed {
		logic up, down, left, right;
		logic fire_a, fire_b;
	} player_ctrl_t;

	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic coin1, coin2;
		logic start1, start2;
		logic pause;
		logic osd;
	} cab_ctrl_t;

endpackage

// ==== dl_router.sv ====
// Download router
// Decodes host download beats into ROM region writes and config strobes
`timescale 1ns/10ps
`include "irem62_params.svh"

module dl_router import irem62_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     dl_valid,
	input  dl_beat_t dl,
	output logic     dl_ready,
	output logic     rom_valid,
	output rom_wr_t  rom_wr,
	input  logic     rom_ready,
	output cfg_wr_t  cfg_wr
);

	logic                      is_rom;
	logic                      is_cfg;
	logic                      is_var;
	logic                      is_dip;
	logic                      in_range;
	logic                      slot_free;
	logic                      rom_take;
	rom_region_e               region;
	logic [`IREM_ADDR_W-1:0]   base;
	logic [`IREM_ADDR_W-1:0]   rel_addr;
	logic [`IREM_OFFSET_W-1:0] offset;

	assign is_rom   = (dl.index == `IREM_IDX_ROM);
	assign is_var   = (dl.index == `IREM_IDX_VARIANT);
	// Only the first two DIP bytes are kept
	assign is_dip   = (dl.index == `IREM_IDX_DIP) && (dl.addr[`IREM_ADDR_W-1:1] == '0);
	assign is_cfg   = is_var | is_dip;
	assign in_range = (dl.addr < `IREM_ROM_END);

	// Output register is empty or drains this cycle
	assign slot_free = ~rom_valid | rom_ready;
	assign dl_ready  = slot_free | (dl_valid & is_cfg);
	assign rom_take  = dl_valid & is_rom & in_range;

	// ==============================
	// Region decode
	// ==============================
	always_comb begin
		if (dl.addr < `IREM_BASE_SND) begin
			region = rom_cpu;
			base   = `IREM_BASE_CPU;
		end else if (dl.addr < `IREM_BASE_GFX1) begin
			region = rom_snd;
			base   = `IREM_BASE_SND;
		end else if (dl.addr < `IREM_BASE_GFX2) begin
			region = rom_gfx1;
			base   = `IREM_BASE_GFX1;
		end else if (dl.addr < `IREM_BASE_GFX3) begin
			region = rom_gfx2;
			base   = `IREM_BASE_GFX2;
		end else if (dl.addr < `IREM_BASE_PROM) begin
			region = rom_gfx3;
			base   = `IREM_BASE_GFX3;
		end else begin
			region = rom_prom;
			base   = `IREM_BASE_PROM;
		end
	end

	assign rel_addr = dl.addr - base;
	assign offset   = rel_addr[`IREM_OFFSET_W-1:0];

	// One-entry output register toward the memory writer
	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_valid <= 1'b0;
		else if (slot_free)
			rom_valid <= rom_take;
	end

	always_ff @(posedge clk_sys) begin
		if (slot_free && rom_take) begin
			rom_wr.region <= region;
			rom_wr.offset <= offset;
			rom_wr.data   <= dl.data;
		end
	end

	// Config strobes, one cycle after the beat
	always_ff @(posedge clk_sys) begin
		cfg_wr.dip_slot <= dl.addr[0];
		cfg_wr.data     <= dl.data;
		if (reset) begin
			cfg_wr.var_wr <= 1'b0;
			cfg_wr.dip_wr <= 1'b0;
		end else begin
			cfg_wr.var_wr <= dl_valid & is_var;
			cfg_wr.dip_wr <= dl_valid & is_dip;
		end
	end

	// A stalled write holds its contents until taken
	a_rom_hold: assert property (@(posedge clk_sys) disable iff (reset)
		rom_valid && !rom_ready |=> rom_valid && $stable(rom_wr));

endmodule

// ==== core_config.sv ====
// Hardware variant and DIP switch capture
// Screen orientation and HDMI aspect ratio
`timescale 1ns/10ps
`include "irem62_params.svh"

module core_config import irem62_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  cfg_wr_t      cfg_wr,
	input  menu_status_t menu_status,
	output logic [7:0]   switches_1,
	output logic [7:0]   switches_2,
	output logic         landscape,
	output logic         ccw,
	output logic [12:0]  video_arx,
	output logic [12:0]  video_ary
);

	logic [7:0] variant;
	logic [1:0] aspect_m1;
	logic       wide;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			variant    <= 8'h00;
			switches_1 <= 8'h00;
			switches_2 <= 8'h00;
		end else begin
			if (cfg_wr.var_wr)
				variant <= cfg_wr.data;
			if (cfg_wr.dip_wr && !cfg_wr.dip_slot)
				switches_1 <= cfg_wr.data;
			if (cfg_wr.dip_wr && cfg_wr.dip_slot)
				switches_2 <= cfg_wr.data;
		end
	end

	// Most variants run on a horizontal monitor
	always_comb begin
		landscape = 1'b1;
		ccw       = 1'b0;
		case (variant)
			`IREM_VAR_BATTROAD: landscape = 1'b0;
			`IREM_VAR_YOUJYUDN: begin
				landscape = 1'b0;
				ccw       = 1'b1;
			end
			default: ;
		endcase
	end

	// Aspect 0 is the original ratio, others select the scaler presets
	assign wide      = menu_status.horizontal | landscape;
	assign aspect_m1 = menu_status.aspect - 2'd1;
	assign video_arx = (menu_status.aspect == 2'd0) ? (wide ? 13'd4 : 13'd3) : {11'd0, aspect_m1};
	assign video_ary = (menu_status.aspect == 2'd0) ? (wide ? 13'd3 : 13'd4) : 13'd0;

endmodule

// ==== reset_gen.sv ====
// Game reset generator
// ROM load tracking and reset hold counter
`timescale 1ns/10ps
`include "irem62_params.svh"

module reset_gen (
	input  logic clk_sys,
	input  logic reset,
	input  logic download_active,
	input  logic reset_req,
	input  logic user_button,
	output logic rom_loaded,
	output logic game_reset
);

	logic        dl_active_d;
	logic        hold;
	logic [15:0] hold_cnt;

	assign hold = reset_req | user_button | ~rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			rom_loaded  <= 1'b0;
			hold_cnt    <= `IREM_RESET_HOLD;
			game_reset  <= 1'b1;
		end else begin
			dl_active_d <= download_active;
			// End of download marks the image as complete
			if (dl_active_d && !download_active)
				rom_loaded <= 1'b1;
			if (hold)
				hold_cnt <= `IREM_RESET_HOLD;
			else if (hold_cnt != 16'd0)
				hold_cnt <= hold_cnt - 16'd1;
			game_reset <= (hold_cnt != 16'd0);
		end
	end

	// The game never runs from a partial image
	a_reset_until_loaded: assert property (@(posedge clk_sys) disable iff (reset)
		!rom_loaded |-> game_reset);

endmodule

// ==== input_mapper.sv ====
// Player control mapping
// USB or user-port joystick selection, merged cabinet controls
`timescale 1ns/10ps

module input_mapper import irem62_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [1:0]  joy_mode,
	input  logic        two_players,
	input  joy_word_u   port1,
	input  joy_word_u   port2,
	input  logic [15:0] usb1,
	input  logic [15:0] usb2,
	output cab_ctrl_t   ctrl
);

	// Mapped word, bits 0 to 9
	// right left down up fire_a fire_b start1 start2 coin pause
	function automatic logic [9:0] map_port(input joy_word_u w);
		logic       start;
		logic       bit11;
		logic [9:0] m;
		// DB9 and DB15 share the start and coin bit positions
		start = w.db9md.start;
		bit11 = w.db9md.mode;
		m       = '0;
		m[5:0]  = w[5:0];
		m[6]    = start;
		// Start with fire_b doubles as coin
		m[8]    = bit11 | (start & w[5]);
		return m;
	endfunction

	function automatic player_ctrl_t to_player(input logic [9:0] m);
		player_ctrl_t p;
		p.right  = m[0];
		p.left   = m[1];
		p.down   = m[2];
		p.up     = m[3];
		p.fire_a = m[4];
		p.fire_b = m[5];
		return p;
	endfunction

	logic       db_en;
	logic       p1_start;
	logic [9:0] p1_map;
	logic [9:0] p2_map;

	assign db_en    = |joy_mode;
	assign p1_start = port1.db9md.start;

	// A single user-port stick moves USB player 1 to player 2
	assign p1_map = db_en ? map_port(port1) : usb1[9:0];
	assign p2_map = !db_en ? usb2[9:0] :
	                two_players ? map_port(port2) : usb1[9:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl.p1     <= to_player(p1_map);
			ctrl.p2     <= to_player(p2_map);
			ctrl.coin1  <= p1_map[8];
			ctrl.coin2  <= p2_map[8];
			ctrl.start1 <= p1_map[6] | p2_map[6];
			ctrl.start2 <= p1_map[7] | p2_map[7];
			ctrl.pause  <= p1_map[9] | p2_map[9];
			ctrl.osd    <= db_en & p1_start & port1[6];
		end
	end

endmodule

// ==== irem62_shell.sv ====
// M62 board shell top level
// Download router, config capture, reset generator and control mapping
`timescale 1ns/10ps

module irem62_shell import irem62_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         dl_valid,
	input  dl_beat_t     dl,
	output logic         dl_ready,
	output logic         rom_valid,
	output rom_wr_t      rom_wr,
	input  logic         rom_ready,
	input  logic         download_active,
	input  logic         user_button,
	input  menu_status_t menu_status,
	input  joy_word_u    port1,
	input  joy_word_u    port2,
	input  logic [15:0]  usb1,
	input  logic [15:0]  usb2,
	output cab_ctrl_t    ctrl,
	output logic [7:0]   switches_1,
	output logic [7:0]   switches_2,
	output logic         landscape,
	output logic         ccw,
	output logic [12:0]  video_arx,
	output logic [12:0]  video_ary,
	output logic         game_reset
);

	cfg_wr_t cfg_wr;

	// ==============================
	// Download side
	// ==============================
	dl_router u_router (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_valid  (dl_valid),
		.dl        (dl),
		.dl_ready  (dl_ready),
		.rom_valid (rom_valid),
		.rom_wr    (rom_wr),
		.rom_ready (rom_ready),
		.cfg_wr    (cfg_wr)
	);

	core_config u_config (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cfg_wr      (cfg_wr),
		.menu_status (menu_status),
		.switches_1  (switches_1),
		.switches_2  (switches_2),
		.landscape   (landscape),
		.ccw         (ccw),
		.video_arx   (video_arx),
		.video_ary   (video_ary)
	);

	// Load status stays internal to the reset block
	reset_gen u_reset (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.download_active (download_active),
		.reset_req       (menu_status.reset_req),
		.user_button     (user_button),
		.rom_loaded      (),
		.game_reset      (game_reset)
	);

	// ==============================
	// Controls
	// ==============================
	input_mapper u_inputs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.joy_mode    (menu_status.joy_mode),
		.two_players (menu_status.two_players),
		.port1       (port1),
		.port2       (port2),
		.usb1        (usb1),
		.usb2        (usb2),
		.ctrl        (ctrl)
	);

endmodule

// ==== tb_irem62.sv ====
// Testbench for the M62 board shell
// Replays download, config, reset and control records from the stim file
`timescale 1ns/10ps
`include "irem62_params.svh"

module tb_irem62 import irem62_pkg::*; ();

	logic         clk_sys;
	logic         reset;
	logic         dl_valid;
	dl_beat_t     dl;
	logic         dl_ready;
	logic         rom_valid;
	rom_wr_t      rom_wr;
	logic         rom_ready;
	logic         download_active;
	logic         user_button;
	menu_status_t menu_status;
	joy_word_u    port1;
	joy_word_u    port2;
	logic [15:0]  usb1;
	logic [15:0]  usb2;
	cab_ctrl_t    ctrl;
	logic [7:0]   switches_1;
	logic [7:0]   switches_2;
	logic         landscape;
	logic         ccw;
	logic [12:0]  video_arx;
	logic [12:0]  video_ary;
	logic         game_reset;

	logic [7:0]   kind [0:127];
	logic [31:0]  fld [0:127][0:6];
	logic [28:0]  exp_q [$];
	logic [28:0]  held_wr;
	logic         held;
	logic         stall;
	logic         ok;
	integer       n_rec;
	integer       seed;

	irem62_shell uut (.*);

	always #5 clk_sys = ~clk_sys;

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
			$display("Verification failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	// Random back-pressure from the memory writer
	always @(negedge clk_sys)
		rom_ready <= stall ? $random(seed) : 1'b1;

	// ==============================
	// ROM write monitor
	// ==============================
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (held) begin
				check("rom_valid", {31'd0, rom_valid}, 32'd1);
				check("rom_wr", {3'd0, rom_wr}, {3'd0, held_wr});
			end
			if (rom_valid && !rom_ready && dl_valid && dl.index == `IREM_IDX_ROM)
				check("dl_ready", {31'd0, dl_ready}, 32'd0);
			held    = rom_valid && !rom_ready;
			held_wr = rom_wr;
			if (rom_valid && rom_ready) begin
				if (exp_q.size() == 0)
					abort_run("ROM write appeared that no kept beat accounts for");
				else
					check("rom_wr", {3'd0, rom_wr}, {3'd0, exp_q.pop_front()});
			end
		end
	end

	// Watchdog sized from the record count
	initial begin
		wait (n_rec > 0);
		repeat (n_rec * 50 + `IREM_RESET_HOLD + 100) @(posedge clk_sys);
		abort_run("Timeout, the simulation did not finish in time");
	end

	task automatic load_stim();
		integer fd;
		integer code;
		integer nf;
		logic [7:0] ch;
		string line;
		fd = $fopen("irem62_stim.txt", "r");
		if (fd == 0)
			abort_run("Could not open the stimulus file");
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", ch);
			if (code != 1)
				break;
			if (ch == "#") begin
				code = $fgets(line, fd);
			end else begin
				case (ch)
					"B": nf = 6;
					"C": nf = 3;
					"K": nf = 4;
					"M": nf = 7;
					"J": nf = 5;
					"D", "S": nf = 1;
					default: nf = 0;
				endcase
				kind[n_rec] = ch;
				for (int j = 0; j < nf; j++)
					code = $fscanf(fd, " %h", fld[n_rec][j]);
				n_rec = n_rec + 1;
			end
		end
		$fclose(fd);
	endtask

	// Offer one beat, hold it until the router takes it
	task automatic send_beat(input integer r);
		dl_valid = 1'b1;
		dl.index = fld[r][0][7:0];
		dl.addr  = fld[r][1][24:0];
		dl.data  = fld[r][2][7:0];
		ok = 1'b0;
		while (!ok) begin
			@(posedge clk_sys);
			ok = dl_ready;
		end
		@(negedge clk_sys);
		dl_valid = 1'b0;
	endtask

	initial begin
		clk_sys = 0;
		reset = 1;
		dl_valid = 0;
		dl = '0;
		rom_ready = 1;
		download_active = 0;
		user_button = 0;
		menu_status = '0;
		port1 = '0;
		port2 = '0;
		usb1 = '0;
		usb2 = '0;
		stall = 0;
		held = 0;
		n_rec = 0;
		seed = 83;
		load_stim();
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 0;
		check("game_reset", {31'd0, game_reset}, 32'd1);
		check("dl_ready", {31'd0, dl_ready}, 32'd1);
		check("rom_valid", {31'd0, rom_valid}, 32'd0);
		for (int r = 0; r < n_rec; r++) begin
			case (kind[r])
				"B": begin
					if (fld[r][3][0])
						exp_q.push_back({fld[r][4][2:0], fld[r][5][17:0], fld[r][2][7:0]});
					send_beat(r);
				end
				"C": send_beat(r);
				"K": begin
					repeat (2) @(negedge clk_sys);
					check("switches_1", {24'd0, switches_1}, fld[r][0]);
					check("switches_2", {24'd0, switches_2}, fld[r][1]);
					check("landscape", {31'd0, landscape}, fld[r][2]);
					check("ccw", {31'd0, ccw}, fld[r][3]);
				end
				"M": begin
					menu_status.reset_req   = fld[r][0][0];
					menu_status.horizontal  = fld[r][1][0];
					menu_status.aspect      = fld[r][2][1:0];
					menu_status.joy_mode    = fld[r][3][1:0];
					menu_status.two_players = fld[r][4][0];
					@(negedge clk_sys);
					check("video_arx", {19'd0, video_arx}, fld[r][5]);
					check("video_ary", {19'd0, video_ary}, fld[r][6]);
				end
				"J": begin
					port1 = fld[r][0][15:0];
					port2 = fld[r][1][15:0];
					usb1  = fld[r][2][15:0];
					usb2  = fld[r][3][15:0];
					@(negedge clk_sys);
					check("ctrl", {14'd0, ctrl}, fld[r][4]);
				end
				"D": begin
					download_active = fld[r][0][0];
					if (!download_active) begin
						repeat (`IREM_RESET_HOLD - 1) @(negedge clk_sys);
						check("game_reset", {31'd0, game_reset}, 32'd1);
						for (int i = 0; i < 5 && game_reset; i++)
							@(negedge clk_sys);
						if (game_reset)
							abort_run("Game reset did not release after the hold time");
					end else begin
						@(negedge clk_sys);
					end
				end
				"S": stall <= fld[r][0][0];
				"W": begin
					while (exp_q.size() != 0)
						@(negedge clk_sys);
				end
				"Q": begin
					menu_status.reset_req = 1'b1;
					@(negedge clk_sys);
					menu_status.reset_req = 1'b0;
					@(negedge clk_sys);
					check("game_reset", {31'd0, game_reset}, 32'd1);
				end
				default: abort_run("Unknown record kind in the stimulus file");
			endcase
		end
		repeat (4) @(negedge clk_sys);
		if (exp_q.size() != 0) begin
			$display("Some kept ROM beats never reached the memory writer");
			$display("Verification failed");
			$fatal(1, "missing writes");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// ==== irem62_stim.txt ====
# B index addr data keep region offset | C index addr data | K sw1 sw2 landscape ccw
# M rst horiz aspect joy_mode two_pl arx ary | J port1 port2 usb1 usb2 ctrl | D S W Q
D 1
B 00 0000010 11 1 0 00010
B 00 0020005 22 1 1 00005
B 00 003ffff 33 1 2 0ffff
B 00 0050100 44 1 3 00100
B 00 009abcd 55 1 4 0abcd
B 00 00a091f 66 1 5 0091f
B 00 00a0920 77 0 0 0
B 07 0000000 88 0 0 0
W
S 1
B 00 0000010 11 1 0 00010
B 00 0020005 22 1 1 00005
B 00 00a0920 77 0 0 0
B 00 009abcd 55 1 4 0abcd
B 00 00a091f 66 1 5 0091f
B 00 003ffff 33 1 2 0ffff
W
S 0
D 0
Q
C 01 0000000 06
K 00 00 0 0
C fe 0000000 a5
C fe 0000001 3c
C fe 0000002 77
K a5 3c 0 0
M 0 0 0 0 0 3 4
M 0 1 0 0 0 4 3
C 01 0000000 0b
K a5 3c 0 1
C 01 0000000 03
K a5 3c 1 0
M 0 0 0 0 0 4 3
M 0 0 2 0 0 1 0
J 0000 0000 0011 0204 06402
J 0000 0000 00c0 0100 0001c
M 0 0 0 1 1 4 3
J 0448 0821 0000 0000 20159
M 0 0 0 2 0 4 3
J 0430 ffff 0002 03ff 03228
M 0 0 0 2 1 4 3
J 0800 0442 0000 0000 00228

// ==== irem62.f ====
+incdir+.
irem62_pkg.sv
dl_router.sv
core_config.sv
reset_gen.sv
input_mapper.sv
irem62_shell.sv
tb_irem62.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the M62 shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f irem62.f --top-module tb_irem62 -o sim_irem62
status=$?
if [ $status -ne 0 ]; then
	echo "Compile step failed"
	exit $status
fi

./obj_dir/sim_irem62
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation reported a failure"
	exit $status
fi
exit 0
